//--- bench/pwire_cases.txt
# name enable short_lo short_hi long_lo long_hi nbits bits nbytes bytes_hex frame_error overflow
# Bits go out leftmost first, bytes_hex lists the expected DATA reads leftmost first
disabled_frame 0 3 5 8 11 8 10100101 0 0 0 0
byte_a5 1 3 5 8 11 8 10100101 1 a5 0 0
two_bytes 1 2 4 7 10 16 0100100000001111 2 12f0 0 0
equal_phases 1 6 6 6 6 8 01010101 1 ff 0 0
frame_error 1 3 5 8 11 11 01011010101 1 5a 1 0
after_clear 1 3 5 8 11 8 11000011 1 c3 0 0
overflow 1 2 4 7 9 40 1000000001000000001000000001000000001000 4 01020408 0 1
after_overflow 1 3 5 8 11 8 01101001 1 96 0 0

//--- bench/pwire_rx_props.sv
`timescale 1ns/10ps

module pwire_rx_props (
    input logic                  sample_clk,
    input logic                  rst_n,
    input pwire_pkg::axil_req_t  req,
    input pwire_pkg::axil_rsp_t  rsp,
    input pwire_pkg::bit_ev_t    bit_ev
);

    int failures = 0;

    b_valid_held: assert property (@(posedge sample_clk) disable iff (!rst_n)
        rsp.bvalid && !req.bready |=> rsp.bvalid)
        else begin
            $error("bvalid dropped before bready was seen");
            failures++;
        end

    // Read data must not move while the host stalls
    r_valid_held: assert property (@(posedge sample_clk) disable iff (!rst_n)
        rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
        else begin
            $error("rvalid or rdata changed before rready was seen");
            failures++;
        end

    bit_or_frame_end: assert property (@(posedge sample_clk) disable iff (!rst_n)
        !(bit_ev.valid && bit_ev.frame_end))
        else begin
            $error("bit valid and frame end asserted together");
            failures++;
        end

    quiet_in_reset: assert property (@(posedge sample_clk)
        !rst_n |-> !(rsp.awready || rsp.wready || rsp.bvalid || rsp.arready || rsp.rvalid))
        else begin
            $error("AXI ready or valid high during reset");
            failures++;
        end

endmodule

bind pwire_rx pwire_rx_props props0 (
    .sample_clk (sample_clk),
    .rst_n      (rst_n),
    .req        (req),
    .rsp        (rsp),
    .bit_ev     (bit_ev)
);

//--- bench/pwire_rx_tb.sv
`timescale 1ns/10ps

module pwire_rx_tb;

    localparam int WAIT_LIMIT = 50;

    logic sample_clk;
    logic rst_n;
    logic data;
    pwire_pkg::axil_req_t req;
    pwire_pkg::axil_rsp_t rsp;

    pwire_rx dut0 (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .data       (data),
        .req        (req),
        .rsp        (rsp)
    );

    initial begin
        sample_clk = 1'b0;
        forever #5 sample_clk = ~sample_clk;
    end

    task automatic compare_value(input string label, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected 0x%08h actual 0x%08h", label, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopping after a failure");
    endtask

    function automatic int pick_width(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic logic [31:0] status_word(input int level, input int ovf, input int ferr);
        pwire_pkg::rx_status_t st;
        st = '0;
        st.level = level[pwire_pkg::FIFO_AW:0];
        st.overflow = ovf[0];
        st.frame_error = ferr[0];
        return 32'(st);
    endfunction

    task automatic hold_line(input logic level, input int cycles);
        data = level;
        repeat (cycles) @(negedge sample_clk);
    endtask

    // Each bit is a low phase then a high phase, a closing low pulse ends the last bit
    task automatic send_frame(input int nbits, input logic [63:0] bits, input int slo,
                              input int shi, input int llo, input int lhi);
        for (int i = nbits - 1; i >= 0; i--) begin
            if (bits[i]) begin
                hold_line(1'b0, pick_width(slo, shi));
                hold_line(1'b1, pick_width(llo, lhi));
            end else begin
                hold_line(1'b0, pick_width(llo, lhi));
                hold_line(1'b1, pick_width(slo, shi));
            end
        end
        hold_line(1'b0, pick_width(slo, shi));
        hold_line(1'b1, pwire_pkg::IDLE_LIMIT + 30);
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] wdata,
                             input logic [1:0] exp_resp, input string label);
        int waited;
        logic [1:0] resp;
        @(negedge sample_clk);
        req.awvalid = 1'b1;
        req.awaddr = addr;
        req.wvalid = 1'b1;
        req.wdata = wdata;
        req.bready = 1'b0;
        waited = 0;
        while (!(rsp.awready && rsp.wready)) begin
            @(negedge sample_clk);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("timeout while waiting for write address and data ready");
        end
        @(negedge sample_clk);
        req.awvalid = 1'b0;
        req.wvalid = 1'b0;
        waited = 0;
        while (!rsp.bvalid) begin
            @(negedge sample_clk);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("timeout while waiting for write response valid");
        end
        resp = rsp.bresp;
        @(negedge sample_clk); // The response must wait one cycle for bready
        compare_value({label, " bvalid held"}, 32'd1, 32'(rsp.bvalid));
        req.bready = 1'b1;
        @(negedge sample_clk);
        req.bready = 1'b0;
        compare_value({label, " bresp"}, 32'(exp_resp), 32'(resp));
    endtask

    // The host may stall rready for a number of cycles before it takes the data
    task automatic read_reg(input logic [3:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp, input int stall, input string label);
        int waited;
        logic [31:0] got;
        logic [1:0] resp;
        @(negedge sample_clk);
        req.arvalid = 1'b1;
        req.araddr = addr;
        req.rready = 1'b0;
        waited = 0;
        while (!rsp.arready) begin
            @(negedge sample_clk);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("timeout while waiting for read address ready");
        end
        @(negedge sample_clk);
        req.arvalid = 1'b0;
        waited = 0;
        while (!rsp.rvalid) begin
            @(negedge sample_clk);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("timeout while waiting for read data valid");
        end
        got = rsp.rdata;
        resp = rsp.rresp;
        for (int i = 0; i < stall; i++) begin
            @(negedge sample_clk);
            compare_value({label, " rvalid held"}, 32'd1, 32'(rsp.rvalid));
            compare_value({label, " rdata held"}, got, rsp.rdata);
        end
        req.rready = 1'b1;
        @(negedge sample_clk);
        req.rready = 1'b0;
        compare_value({label, " rresp"}, 32'(exp_resp), 32'(resp));
        compare_value({label, " rdata"}, exp_data, got);
    endtask

    task automatic run_case(input string name, input int en, input int slo, input int shi,
                            input int llo, input int lhi, input int nbits,
                            input logic [63:0] bits, input int nbytes,
                            input logic [39:0] bytes_exp, input int ferr, input int ovf);
        logic [7:0] exp_byte;
        write_reg(pwire_pkg::ADDR_CTRL, 32'(en), pwire_pkg::RESP_OKAY, {name, " enable write"});
        read_reg(pwire_pkg::ADDR_CTRL, 32'(en), pwire_pkg::RESP_OKAY, 0, {name, " ctrl"});
        send_frame(nbits, bits, slo, shi, llo, lhi);
        read_reg(pwire_pkg::ADDR_STATUS, status_word(nbytes, ovf, ferr), pwire_pkg::RESP_OKAY,
                 0, {name, " status"});
        for (int i = 0; i < nbytes; i++) begin
            exp_byte = 8'(bytes_exp >> (8 * (nbytes - 1 - i)));
            read_reg(pwire_pkg::ADDR_DATA, {23'd0, 1'b1, exp_byte}, pwire_pkg::RESP_OKAY, 0,
                     $sformatf("%s byte %0d", name, i));
        end
        read_reg(pwire_pkg::ADDR_DATA, 32'd0, pwire_pkg::RESP_OKAY, 0, {name, " empty read"});
        if (ferr != 0 || ovf != 0) begin
            write_reg(pwire_pkg::ADDR_CTRL, 32'(en) | 32'd2, pwire_pkg::RESP_OKAY,
                      {name, " clear write"});
            read_reg(pwire_pkg::ADDR_STATUS, 32'd0, pwire_pkg::RESP_OKAY, 0,
                     {name, " status after clear"});
        end
    endtask

    task automatic run_cases_file();
        int fd;
        int fields;
        int ran;
        string line;
        string name;
        int en, slo, shi, llo, lhi, nbits, nbytes, ferr, ovf;
        logic [63:0] bits;
        logic [39:0] bytes_exp;
        ran = 0;
        fd = $fopen("bench/pwire_cases.txt", "r");
        if (fd == 0)
            report_failure("the cases file bench/pwire_cases.txt could not be opened");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            fields = $sscanf(line, "%s %d %d %d %d %d %d %b %d %h %d %d", name, en, slo, shi,
                             llo, lhi, nbits, bits, nbytes, bytes_exp, ferr, ovf);
            if (fields != 12)
                report_failure($sformatf("a case line is malformed, got %0d fields", fields));
            run_case(name, en, slo, shi, llo, lhi, nbits, bits, nbytes, bytes_exp, ferr, ovf);
            ran++;
        end
        $fclose(fd);
        compare_value("cases read", 32'd8, 32'(ran));
    endtask

    initial begin
        void'($urandom(689));
        rst_n = 1'b0;
        data = 1'b1; // Idle line is high
        req = '0;
        repeat (5) @(negedge sample_clk);
        rst_n = 1'b1;

        read_reg(pwire_pkg::ADDR_STATUS, 32'd0, pwire_pkg::RESP_OKAY, 0, "reset status");
        read_reg(pwire_pkg::ADDR_CTRL, 32'd0, pwire_pkg::RESP_OKAY, 0, "reset ctrl");

        run_cases_file();

        read_reg(4'hC, 32'd0, pwire_pkg::RESP_SLVERR, 0, "unmapped read");
        write_reg(4'hC, 32'd3, pwire_pkg::RESP_SLVERR, "unmapped write");
        read_reg(pwire_pkg::ADDR_CTRL, 32'd1, pwire_pkg::RESP_OKAY, 6, "stalled ctrl read");

        if (dut0.props0.failures == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "bound assertions failed during the run");
        end
    end

endmodule

//--- list.f
logic/pwire_pkg.sv
logic/line_sync.sv
logic/phase_timer.sv
logic/bit_sequencer.sv
logic/byte_fifo.sv
logic/axil_regs.sv
logic/pwire_rx.sv
bench/pwire_rx_props.sv
bench/pwire_rx_tb.sv

//--- logic/axil_regs.sv
`timescale 1ns/10ps

module axil_regs (
    input  logic                   sample_clk,
    input  logic                   rst_n,
    input  pwire_pkg::axil_req_t   req,
    output pwire_pkg::axil_rsp_t   rsp,
    input  pwire_pkg::rx_status_t  status,
    input  logic [8:0]             rd_byte,
    output logic                   enable,
    output logic                   clear,
    output logic                   pop
);

    logic aw_ready;
    logic b_valid;
    logic [1:0] b_resp;
    logic ar_ready;
    logic r_valid;
    logic [1:0] r_resp;
    logic [pwire_pkg::AXI_DW-1:0] r_data;
    logic [pwire_pkg::AXI_DW-1:0] rd_mux;
    logic rd_hit;
    logic wr_fire;
    logic rd_fire;

    assign wr_fire = aw_ready && req.awvalid && req.wvalid;
    assign rd_fire = ar_ready && req.arvalid;

    always_comb begin
        rd_mux = '0;
        rd_hit = 1'b1;
        case (req.araddr)
            pwire_pkg::ADDR_CTRL:   rd_mux[0] = enable;
            pwire_pkg::ADDR_STATUS: rd_mux[$bits(pwire_pkg::rx_status_t)-1:0] = status;
            pwire_pkg::ADDR_DATA:   rd_mux[8:0] = rd_byte;
            default:                rd_hit = 1'b0;
        endcase
    end

    // Write path, address and data are taken in the same beat
    always_ff @(posedge sample_clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_ready <= 1'b0;
            b_valid <= 1'b0;
            enable <= 1'b0;
            clear <= 1'b0;
        end else begin
            clear <= 1'b0;
            if (wr_fire) begin
                aw_ready <= 1'b0;
                b_valid <= 1'b1;
                if (req.awaddr == pwire_pkg::ADDR_CTRL) begin
                    enable <= req.wdata[0];
                    clear <= req.wdata[1];
                end
            end else if (!aw_ready && !b_valid && req.awvalid && req.wvalid) begin
                aw_ready <= 1'b1;
            end

            if (b_valid && req.bready)
                b_valid <= 1'b0;
        end
    end

    always_ff @(posedge sample_clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_ready <= 1'b0;
            r_valid <= 1'b0;
            pop <= 1'b0;
        end else begin
            pop <= 1'b0;
            if (rd_fire) begin
                ar_ready <= 1'b0;
                r_valid <= 1'b1;
                pop <= (req.araddr == pwire_pkg::ADDR_DATA); // Head leaves after it is captured
            end else if (!ar_ready && !r_valid && req.arvalid) begin
                ar_ready <= 1'b1;
            end

            if (r_valid && req.rready)
                r_valid <= 1'b0;
        end
    end

    always_ff @(posedge sample_clk) begin
        if (wr_fire) begin
            if (req.awaddr == pwire_pkg::ADDR_CTRL || req.awaddr == pwire_pkg::ADDR_STATUS ||
                req.awaddr == pwire_pkg::ADDR_DATA)
                b_resp <= pwire_pkg::RESP_OKAY;
            else
                b_resp <= pwire_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            r_data <= rd_mux;
            r_resp <= rd_hit ? pwire_pkg::RESP_OKAY : pwire_pkg::RESP_SLVERR;
        end
    end

    assign rsp.awready = aw_ready;
    assign rsp.wready = aw_ready;
    assign rsp.bvalid = b_valid;
    assign rsp.bresp = b_resp;
    assign rsp.arready = ar_ready;
    assign rsp.rvalid = r_valid;
    assign rsp.rdata = r_data;
    assign rsp.rresp = r_resp;

endmodule

//--- logic/bit_sequencer.sv
`timescale 1ns/10ps

module bit_sequencer (
    input  logic                sample_clk,
    input  logic                rst_n,
    input  logic                enable,
    input  pwire_pkg::line_ev_t ev,
    input  pwire_pkg::phase_t   phase,
    output pwire_pkg::bit_ev_t  bit_ev
);

    pwire_pkg::seq_state_e state;
    pwire_pkg::seq_state_e state_nxt;
    pwire_pkg::bit_ev_t bit_nxt;

    always_comb begin
        state_nxt = state;
        bit_nxt = '0;

        case (state)
            pwire_pkg::wait_line_high: begin
                if (ev.level)
                    state_nxt = pwire_pkg::wait_first_fall;
            end

            pwire_pkg::wait_first_fall: begin
                if (ev.fall)
                    state_nxt = pwire_pkg::read_low; // First low pulse opens the frame
            end

            pwire_pkg::read_low: begin
                if (ev.rise)
                    state_nxt = pwire_pkg::read_high;
            end

            pwire_pkg::read_high: begin
                if (ev.fall) begin
                    state_nxt = pwire_pkg::read_low;
                    bit_nxt.valid = 1'b1;
                    // Equal phases decode as 1
                    bit_nxt.value = !(phase.low_len > phase.high_len);
                end else if (phase.idle) begin
                    state_nxt = pwire_pkg::wait_first_fall;
                    bit_nxt.frame_end = 1'b1;
                end
            end

            default: begin
                state_nxt = pwire_pkg::wait_line_high;
            end
        endcase

        if (!enable) begin
            state_nxt = pwire_pkg::wait_line_high;
            bit_nxt = '0;
        end
    end

    always_ff @(posedge sample_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pwire_pkg::wait_line_high;
            bit_ev <= '0;
        end else begin
            state <= state_nxt;
            bit_ev <= bit_nxt;
        end
    end

endmodule

//--- logic/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo (
    input  logic                   sample_clk,
    input  logic                   rst_n,
    input  pwire_pkg::bit_ev_t     bit_ev,
    input  logic                   clear,
    input  logic                   pop,
    output logic [8:0]             rd_byte,
    output pwire_pkg::rx_status_t  status
);

    logic [7:0] shift_q;
    logic [2:0] bit_cnt;
    logic [7:0] mem [pwire_pkg::FIFO_DEPTH];
    logic [pwire_pkg::FIFO_AW-1:0] wr_ptr;
    logic [pwire_pkg::FIFO_AW-1:0] rd_ptr;
    logic [pwire_pkg::FIFO_AW:0] count;
    logic overflow;
    logic frame_error;
    logic [7:0] next_byte;
    logic push;
    logic push_ok;
    logic pop_ok;
    logic full;
    logic empty;

    assign next_byte = {bit_ev.value, shift_q[7:1]}; // LSB first, new bit enters at the top
    assign push = bit_ev.valid && (bit_cnt == 3'd7) && !clear;
    assign empty = (count == '0);
    assign full = (count == pwire_pkg::FIFO_DEPTH);
    assign pop_ok = pop && !empty;
    assign push_ok = push && (!full || pop_ok);

    always_ff @(posedge sample_clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            frame_error <= 1'b0;
        end else if (clear) begin
            bit_cnt <= '0;
            frame_error <= 1'b0;
        end else if (bit_ev.valid) begin
            bit_cnt <= bit_cnt + 1'b1;
        end else if (bit_ev.frame_end) begin
            if (bit_cnt != '0)
                frame_error <= 1'b1; // Partial byte is dropped
            bit_cnt <= '0;
        end
    end

    always_ff @(posedge sample_clk) begin
        if (bit_ev.valid)
            shift_q <= next_byte;
        if (push_ok)
            mem[wr_ptr] <= next_byte;
    end

    always_ff @(posedge sample_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            if (push_ok && !pop_ok)
                count <= count + 1'b1;
            else if (pop_ok && !push_ok)
                count <= count - 1'b1;

            if (clear)
                overflow <= 1'b0;
            else if (push && !push_ok)
                overflow <= 1'b1;
        end
    end

    assign rd_byte = empty ? 9'd0 : {1'b1, mem[rd_ptr]};

    assign status.level = count;
    assign status.overflow = overflow;
    assign status.frame_error = frame_error;
    assign status.busy = (bit_cnt != '0);

endmodule

//--- logic/line_sync.sv
`timescale 1ns/10ps

module line_sync (
    input  logic                 sample_clk,
    input  logic                 rst_n,
    input  logic                 data,
    output pwire_pkg::line_ev_t  ev
);

    logic sync_q1;
    logic sync_q2;

    // The idle line is high, so every stage resets to 1
    always_ff @(posedge sample_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
            ev.level <= 1'b1;
            ev.rise <= 1'b0;
            ev.fall <= 1'b0;
        end else begin
            sync_q1 <= data;
            sync_q2 <= sync_q1;
            ev.level <= sync_q2; // Edge register holds the previous level
            ev.rise <= sync_q2 && !ev.level;
            ev.fall <= !sync_q2 && ev.level;
        end
    end

endmodule

//--- logic/phase_timer.sv
`timescale 1ns/10ps

module phase_timer (
    input  logic               sample_clk,
    input  logic               rst_n,
    input  pwire_pkg::line_ev_t ev,
    output pwire_pkg::phase_t  phase
);

    logic [pwire_pkg::CNT_W-1:0] low_cnt;
    logic [pwire_pkg::CNT_W-1:0] high_cnt;
    logic [pwire_pkg::CNT_W-1:0] low_len_q;
    logic [pwire_pkg::CNT_W-1:0] high_len_q;
    logic low_sat;
    logic high_sat;

    assign low_sat = (low_cnt == pwire_pkg::IDLE_LIMIT);
    assign high_sat = (high_cnt == pwire_pkg::IDLE_LIMIT);

    // The edge cycle already belongs to the new phase, so a restart loads 1
    always_ff @(posedge sample_clk or negedge rst_n) begin
        if (!rst_n) begin
            low_cnt <= '0;
            high_cnt <= '0;
        end else begin
            if (ev.fall)
                low_cnt <= 1;
            else if (!ev.level && !low_sat)
                low_cnt <= low_cnt + 1'b1;

            if (ev.rise)
                high_cnt <= 1;
            else if (ev.level && !high_sat)
                high_cnt <= high_cnt + 1'b1;
        end
    end

    always_ff @(posedge sample_clk) begin
        if (ev.rise)
            low_len_q <= low_cnt; // Low phase just finished
        if (ev.fall)
            high_len_q <= high_cnt;
    end

    // Bypass so a length is usable in the cycle of its closing edge
    assign phase.low_len = ev.rise ? low_cnt : low_len_q;
    assign phase.high_len = ev.fall ? high_cnt : high_len_q;
    assign phase.idle = ev.level && high_sat;

endmodule

//--- logic/pwire_pkg.sv
package pwire_pkg;

    localparam int CNT_W = 8;
    localparam logic [CNT_W-1:0] IDLE_LIMIT = 8'd200; // Phase counts stop here
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    localparam int AXI_AW = 4;
    localparam int AXI_DW = 32;
    localparam logic [AXI_AW-1:0] ADDR_CTRL = 4'h0;
    localparam logic [AXI_AW-1:0] ADDR_STATUS = 4'h4;
    localparam logic [AXI_AW-1:0] ADDR_DATA = 4'h8;
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        wait_line_high,
        wait_first_fall,
        read_low,
        read_high
    } seq_state_e;

    typedef struct packed {
        logic level;
        logic rise;
        logic fall;
    } line_ev_t;

    typedef struct packed {
        logic [CNT_W-1:0] low_len;
        logic [CNT_W-1:0] high_len;
        logic idle;
    } phase_t;

    typedef struct packed {
        logic valid;
        logic value;
        logic frame_end;
    } bit_ev_t;

    typedef struct packed {
        logic [FIFO_AW:0] level;
        logic overflow;
        logic frame_error;
        logic busy;
    } rx_status_t;

    typedef struct packed {
        logic awvalid;
        logic [AXI_AW-1:0] awaddr;
        logic wvalid;
        logic [AXI_DW-1:0] wdata;
        logic bready;
        logic arvalid;
        logic [AXI_AW-1:0] araddr;
        logic rready;
    } axil_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        logic [AXI_DW-1:0] rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage

//--- logic/pwire_rx.sv
`timescale 1ns/10ps

module pwire_rx (
    input  logic                  sample_clk,
    input  logic                  rst_n,
    input  logic                  data,
    input  pwire_pkg::axil_req_t  req,
    output pwire_pkg::axil_rsp_t  rsp
);

    pwire_pkg::line_ev_t line_ev;
    pwire_pkg::phase_t phase;
    pwire_pkg::bit_ev_t bit_ev;
    pwire_pkg::rx_status_t status;
    logic [8:0] rd_byte;
    logic enable;
    logic clear;
    logic pop;

    line_sync line_sync0 (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .data       (data),
        .ev         (line_ev)
    );

    phase_timer phase_timer0 (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .ev         (line_ev),
        .phase      (phase)
    );

    bit_sequencer bit_sequencer0 (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .ev         (line_ev),
        .phase      (phase),
        .bit_ev     (bit_ev)
    );

    byte_fifo byte_fifo0 (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .bit_ev     (bit_ev),
        .clear      (clear),
        .pop        (pop),
        .rd_byte    (rd_byte),
        .status     (status)
    );

    axil_regs axil_regs0 (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .req        (req),
        .rsp        (rsp),
        .status     (status),
        .rd_byte    (rd_byte),
        .enable     (enable),
        .clear      (clear),
        .pop        (pop)
    );

endmodule
